/* mips_pkg.sv */
package mips_pkg;

	////////////////////////////////////////////////////////////
	// Instruction fields
	////////////////////////////////////////////////////////////

	// Primary opcode in instr[31:26]
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'h00,
		OP_J       = 6'h02,
		OP_JAL     = 6'h03,
		OP_BEQ     = 6'h04,
		OP_ADDI    = 6'h08,
		OP_ADDIU   = 6'h09,
		OP_SLTI    = 6'h0a,
		OP_SLTIU   = 6'h0b,
		OP_ANDI    = 6'h0c,
		OP_ORI     = 6'h0d,
		OP_XORI    = 6'h0e,
		OP_LUI     = 6'h0f,
		OP_LW      = 6'h23,
		OP_SW      = 6'h2b
	} opcode_e;

	// SPECIAL function field in instr[5:0]
	typedef enum logic [5:0] {
		F_SLL  = 6'h00,
		F_SRL  = 6'h02,
		F_SRA  = 6'h03,
		F_SLLV = 6'h04,
		F_SRLV = 6'h06,
		F_SRAV = 6'h07,
		F_JR   = 6'h08,
		F_ADD  = 6'h20,
		F_ADDU = 6'h21,
		F_SUB  = 6'h22,
		F_SUBU = 6'h23,
		F_AND  = 6'h24,
		F_OR   = 6'h25,
		F_XOR  = 6'h26,
		F_NOR  = 6'h27,
		F_SLT  = 6'h2a,
		F_SLTU = 6'h2b
	} funct_e;

	////////////////////////////////////////////////////////////
	// Control encodings
	////////////////////////////////////////////////////////////

	typedef enum logic [3:0] {
		ALU_AND  = 4'd0,
		ALU_OR   = 4'd1,
		ALU_ADD  = 4'd2,
		ALU_SUB  = 4'd3,
		ALU_LUI  = 4'd4,
		ALU_SLL  = 4'd5,
		ALU_SRL  = 4'd6,
		ALU_SRA  = 4'd7,
		ALU_XOR  = 4'd8,
		ALU_NOR  = 4'd9,
		ALU_SLT  = 4'd10,
		ALU_SLTU = 4'd11
	} alu_op_e;

	typedef enum logic [1:0] {PC_SEQ, PC_BRANCH, PC_JUMP, PC_REG} pc_sel_e;
	typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_LINK} wb_sel_e;
	typedef enum logic [1:0] {SRCB_RT, SRCB_ZEXT, SRCB_SEXT} srcb_sel_e;

	typedef struct packed {
		pc_sel_e   pc_sel;
		wb_sel_e   wb_sel;
		alu_op_e   alu_op;
		srcb_sel_e srcb_sel;
		logic      srca_shamt;
		logic      mem_we;
		logic      reg_we;
		logic      link;
		logic      wr_rt;
	} ctrl_t;

	// One record per executed instruction
	typedef struct packed {
		logic        valid;
		logic [31:0] pc;
		logic [31:0] instr;
		logic        reg_we;
		logic [4:0]  wr_reg;
		logic [31:0] wr_data;
		logic        mem_we;
		logic [31:0] mem_addr;
		logic [31:0] mem_data;
	} retire_t;

endpackage

/* mips_controller.sv */
`timescale 1ns/1ps

module mips_controller (
	input  logic [31:0]     instr,
	input  logic            eq,
	output mips_pkg::ctrl_t ctrl
);
	import mips_pkg::*;

	opcode_e op;
	funct_e  fn;
	logic    special;

	assign op = opcode_e'(instr[31:26]);
	assign fn = funct_e'(instr[5:0]);
	assign special = (op == OP_SPECIAL);

	////////////////////////////////////////////////////////////
	// One-hot instruction classes
	////////////////////////////////////////////////////////////

	logic c_addu, c_subu, c_add, c_sub;
	logic c_and, c_or, c_xor, c_nor;
	logic c_slt, c_sltu, c_jr;
	logic c_sll, c_srl, c_sra, c_sllv, c_srlv, c_srav;
	logic c_addi, c_addiu, c_andi, c_ori, c_xori, c_lui;
	logic c_slti, c_sltiu, c_lw, c_sw, c_beq, c_j, c_jal;
	logic r_write;
	logic i_write;

	assign c_addu = special && (fn == F_ADDU);
	assign c_subu = special && (fn == F_SUBU);
	assign c_add  = special && (fn == F_ADD);
	assign c_sub  = special && (fn == F_SUB);
	assign c_and  = special && (fn == F_AND);
	assign c_or   = special && (fn == F_OR);
	assign c_xor  = special && (fn == F_XOR);
	assign c_nor  = special && (fn == F_NOR);
	assign c_slt  = special && (fn == F_SLT);
	assign c_sltu = special && (fn == F_SLTU);
	assign c_sll  = special && (fn == F_SLL);
	assign c_srl  = special && (fn == F_SRL);
	assign c_sra  = special && (fn == F_SRA);
	assign c_sllv = special && (fn == F_SLLV);
	assign c_srlv = special && (fn == F_SRLV);
	assign c_srav = special && (fn == F_SRAV);
	assign c_jr   = special && (fn == F_JR);

	assign c_addi  = (op == OP_ADDI);
	assign c_addiu = (op == OP_ADDIU);
	assign c_andi  = (op == OP_ANDI);
	assign c_ori   = (op == OP_ORI);
	assign c_xori  = (op == OP_XORI);
	assign c_lui   = (op == OP_LUI);
	assign c_slti  = (op == OP_SLTI);
	assign c_sltiu = (op == OP_SLTIU);
	assign c_lw    = (op == OP_LW);
	assign c_sw    = (op == OP_SW);
	assign c_beq   = (op == OP_BEQ);
	assign c_j     = (op == OP_J);
	assign c_jal   = (op == OP_JAL);

	// R-type writers go to rd, I-type writers go to rt
	assign r_write = c_addu | c_subu | c_add | c_sub | c_and | c_or | c_xor | c_nor |
		c_slt | c_sltu | c_sll | c_srl | c_sra | c_sllv | c_srlv | c_srav;
	assign i_write = c_addi | c_addiu | c_andi | c_ori | c_xori | c_lui |
		c_slti | c_sltiu | c_lw;

	////////////////////////////////////////////////////////////
	// Control fields
	////////////////////////////////////////////////////////////

	always_comb begin
		ctrl.pc_sel = c_jr ? PC_REG :
			(c_j || c_jal) ? PC_JUMP :
			(c_beq && eq) ? PC_BRANCH : PC_SEQ;

		ctrl.wb_sel = c_jal ? WB_LINK :
			c_lw ? WB_MEM : WB_ALU;

		// First matching class wins
		ctrl.alu_op = (c_sltu || c_sltiu) ? ALU_SLTU :
			(c_slt || c_slti) ? ALU_SLT :
			c_nor ? ALU_NOR :
			(c_xor || c_xori) ? ALU_XOR :
			(c_sra || c_srav) ? ALU_SRA :
			(c_srl || c_srlv) ? ALU_SRL :
			(c_sll || c_sllv) ? ALU_SLL :
			c_lui ? ALU_LUI :
			(c_subu || c_sub) ? ALU_SUB :
			(c_addu || c_add || c_addi || c_addiu || c_lw || c_sw) ? ALU_ADD :
			(c_or || c_ori) ? ALU_OR : ALU_AND;

		ctrl.srcb_sel = (c_lw || c_sw || c_addi || c_addiu || c_slti || c_sltiu) ? SRCB_SEXT :
			(c_ori || c_lui || c_andi || c_xori) ? SRCB_ZEXT : SRCB_RT;

		// Fixed shifts take the amount from shamt
		ctrl.srca_shamt = c_sll | c_srl | c_sra;
		ctrl.mem_we     = c_sw;
		ctrl.reg_we     = r_write | i_write | c_jal;
		ctrl.link       = c_jal;
		ctrl.wr_rt      = i_write;
	end

endmodule

/* mips_fetch.sv */
`timescale 1ns/1ps

module mips_fetch #(
	parameter int IMEM_DEPTH = 256
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              run,
	input  logic              load_req,
	input  logic [31:0]       load_addr,
	input  logic [31:0]       load_data,
	output logic              load_ack,
	input  mips_pkg::pc_sel_e pc_sel,
	input  logic [31:0]       branch_target,
	input  logic [31:0]       jump_target,
	input  logic [31:0]       reg_target,
	output logic [31:0]       pc,
	output logic [31:0]       instr
);
	import mips_pkg::*;

	localparam int IA_W = $clog2(IMEM_DEPTH);

	typedef enum logic {LD_IDLE, LD_ACK} ld_state_e;

	logic [31:0]     imem [IMEM_DEPTH];
	logic [IA_W-1:0] fetch_idx;
	logic [IA_W-1:0] load_idx;
	logic [31:0]     pc_next;
	logic            load_wr;
	ld_state_e       ld_state;

	////////////////////////////////////////////////////////////
	// Program counter
	////////////////////////////////////////////////////////////

	always_comb begin
		case (pc_sel)
			PC_BRANCH: pc_next = branch_target;
			PC_JUMP:   pc_next = jump_target;
			PC_REG:    pc_next = reg_target;
			default:   pc_next = pc + 32'd4;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			pc <= '0;
		else if (run)
			pc <= pc_next;
	end

	// Word index wraps at the memory depth
	assign fetch_idx = IA_W'(pc[31:2] % 30'(IMEM_DEPTH));
	assign instr = imem[fetch_idx];

	////////////////////////////////////////////////////////////
	// Program loader
	////////////////////////////////////////////////////////////

	assign load_idx = IA_W'(load_addr % 32'(IMEM_DEPTH));
	// Requests wait while the core runs
	assign load_wr = (ld_state == LD_IDLE) && load_req && !run;
	assign load_ack = (ld_state == LD_ACK);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ld_state <= LD_IDLE;
		end else begin
			case (ld_state)
				LD_IDLE: if (load_wr) ld_state <= LD_ACK;
				LD_ACK:  if (!load_req) ld_state <= LD_IDLE;
				default: ld_state <= LD_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (load_wr)
			imem[load_idx] <= load_data;
	end

endmodule

/* mips_regfile.sv */
`timescale 1ns/1ps

module mips_regfile (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        we,
	input  logic [4:0]  wr_addr,
	input  logic [31:0] wr_data,
	input  logic [4:0]  rs_addr,
	input  logic [4:0]  rt_addr,
	output logic [31:0] rs_data,
	output logic [31:0] rt_data
);

	logic [31:0] regs [32];

	// All entries clear in the single reset cycle
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (we && (wr_addr != 5'd0)) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// r0 reads as zero
	assign rs_data = (rs_addr == 5'd0) ? 32'd0 : regs[rs_addr];
	assign rt_data = (rt_addr == 5'd0) ? 32'd0 : regs[rt_addr];

endmodule

/* mips_execute.sv */
`timescale 1ns/1ps

module mips_execute (
	input  logic [31:0]     instr,
	input  logic [31:0]     pc,
	input  logic [31:0]     rs_data,
	input  logic [31:0]     rt_data,
	input  mips_pkg::ctrl_t ctrl,
	output logic [31:0]     alu_result,
	output logic            eq,
	output logic [31:0]     branch_target,
	output logic [31:0]     jump_target
);
	import mips_pkg::*;

	logic [31:0] imm_zext;
	logic [31:0] imm_sext;
	logic [31:0] shamt;
	logic [31:0] pc_plus4;
	logic [31:0] src_a;
	logic [31:0] src_b;
	logic [4:0]  sh;

	////////////////////////////////////////////////////////////
	// Immediates and operands
	////////////////////////////////////////////////////////////

	assign imm_zext = {16'd0, instr[15:0]};
	assign imm_sext = {{16{instr[15]}}, instr[15:0]};
	assign shamt    = {27'd0, instr[10:6]};

	assign src_a = ctrl.srca_shamt ? shamt : rs_data;

	always_comb begin
		case (ctrl.srcb_sel)
			SRCB_ZEXT: src_b = imm_zext;
			SRCB_SEXT: src_b = imm_sext;
			default:   src_b = rt_data;
		endcase
	end

	////////////////////////////////////////////////////////////
	// ALU
	////////////////////////////////////////////////////////////

	// Shifts move B by the low five bits of A
	assign sh = src_a[4:0];

	always_comb begin
		case (ctrl.alu_op)
			ALU_AND:  alu_result = src_a & src_b;
			ALU_OR:   alu_result = src_a | src_b;
			ALU_ADD:  alu_result = src_a + src_b;
			ALU_SUB:  alu_result = src_a - src_b;
			ALU_LUI:  alu_result = {src_b[15:0], 16'd0};
			ALU_SLL:  alu_result = src_b << sh;
			ALU_SRL:  alu_result = src_b >> sh;
			ALU_SRA:  alu_result = $unsigned($signed(src_b) >>> sh);
			ALU_XOR:  alu_result = src_a ^ src_b;
			ALU_NOR:  alu_result = ~(src_a | src_b);
			ALU_SLT:  alu_result = {31'd0, $signed(src_a) < $signed(src_b)};
			ALU_SLTU: alu_result = {31'd0, src_a < src_b};
			default:  alu_result = 32'd0;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Branch and jump
	////////////////////////////////////////////////////////////

	assign eq = (rs_data == rt_data);
	assign pc_plus4 = pc + 32'd4;

	// Offset counts from pc+4 as there is no delay slot
	assign branch_target = pc_plus4 + {imm_sext[29:0], 2'b00};
	assign jump_target = {pc_plus4[31:28], instr[25:0], 2'b00};

endmodule

/* mips_data_mem.sv */
`timescale 1ns/1ps

module mips_data_mem #(
	parameter int DMEM_DEPTH = 256
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        we,
	input  logic [31:0] addr,
	input  logic [31:0] wdata,
	output logic [31:0] rdata
);

	localparam int DA_W = $clog2(DMEM_DEPTH);

	logic [31:0]     mem [DMEM_DEPTH];
	logic [DA_W-1:0] idx;

	// Byte address to word index wrapped at depth
	assign idx = DA_W'(addr[31:2] % 30'(DMEM_DEPTH));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < DMEM_DEPTH; i++)
				mem[i] <= '0;
		end else if (we) begin
			mem[idx] <= wdata;
		end
	end

	assign rdata = mem[idx];

endmodule

/* mips_core.sv */
`timescale 1ns/1ps

module mips_core #(
	parameter int IMEM_DEPTH = 256,
	parameter int DMEM_DEPTH = 256
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              run,
	input  logic              load_req,
	input  logic [31:0]       load_addr,
	input  logic [31:0]       load_data,
	output logic              load_ack,
	output mips_pkg::retire_t retire
);
	import mips_pkg::*;

	logic [31:0] pc;
	logic [31:0] instr;
	ctrl_t       ctrl;
	logic        eq;
	logic [31:0] rs_data;
	logic [31:0] rt_data;
	logic [31:0] alu_result;
	logic [31:0] branch_target;
	logic [31:0] jump_target;
	logic [31:0] mem_rdata;
	logic [31:0] pc_plus4;
	logic [4:0]  wr_addr;
	logic [31:0] wr_data;

	mips_fetch #(.IMEM_DEPTH(IMEM_DEPTH)) fetch_i (
		.clk, .rst_n, .run,
		.load_req, .load_addr, .load_data, .load_ack,
		.pc_sel(ctrl.pc_sel), .branch_target, .jump_target,
		.reg_target(rs_data), .pc, .instr
	);

	mips_controller controller_i (.instr, .eq, .ctrl);

	mips_regfile regfile_i (
		.clk, .rst_n, .we(ctrl.reg_we && run), .wr_addr, .wr_data,
		.rs_addr(instr[25:21]), .rt_addr(instr[20:16]), .rs_data, .rt_data
	);

	mips_execute execute_i (
		.instr, .pc, .rs_data, .rt_data, .ctrl,
		.alu_result, .eq, .branch_target, .jump_target
	);

	mips_data_mem #(.DMEM_DEPTH(DMEM_DEPTH)) data_mem_i (
		.clk, .rst_n, .we(ctrl.mem_we && run), .addr(alu_result),
		.wdata(rt_data), .rdata(mem_rdata)
	);

	////////////////////////////////////////////////////////////
	// Write-back
	////////////////////////////////////////////////////////////

	assign pc_plus4 = pc + 32'd4;
	assign wr_addr = ctrl.link ? 5'd31 : (ctrl.wr_rt ? instr[20:16] : instr[15:11]);

	always_comb begin
		case (ctrl.wb_sel)
			WB_MEM:  wr_data = mem_rdata;
			WB_LINK: wr_data = pc_plus4;
			default: wr_data = alu_result;
		endcase
	end

	// Retire trace lags execution by one cycle
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			retire <= '0;
		end else begin
			retire.valid    <= run;
			retire.pc       <= pc;
			retire.instr    <= instr;
			retire.reg_we   <= ctrl.reg_we;
			retire.wr_reg   <= wr_addr;
			retire.wr_data  <= wr_data;
			retire.mem_we   <= ctrl.mem_we;
			retire.mem_addr <= {2'b00, alu_result[31:2]};
			retire.mem_data <= rt_data;
		end
	end

endmodule

/* tb_iss.svh */
////////////////////////////////////////////////////////////
// Reference model state
////////////////////////////////////////////////////////////

logic [31:0] m_pc;
logic [31:0] m_regs [32];
logic [31:0] m_dmem [DMEM_DEPTH];
logic [31:0] m_imem [IMEM_DEPTH];
logic [31:0] lcg_state = 32'h9fa70289;

// Function codes and opcodes the random generator picks from
localparam logic [5:0] R_FUNCTS [17] = '{
	F_ADDU, F_SUBU, F_ADD, F_SUB, F_AND, F_OR, F_XOR, F_NOR, F_SLT,
	F_SLTU, F_SLL, F_SRL, F_SRA, F_SLLV, F_SRLV, F_SRAV, F_JR
};
localparam logic [5:0] I_OPS [13] = '{
	OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI,
	OP_LUI, OP_LW, OP_SW, OP_BEQ, OP_J, OP_JAL
};

function automatic void model_reset();
	m_pc = 32'd0;
	for (int i = 0; i < 32; i++)
		m_regs[i] = 32'd0;
	for (int i = 0; i < DMEM_DEPTH; i++)
		m_dmem[i] = 32'd0;
endfunction

// Executes one instruction of the model and returns its expected record
function automatic retire_t iss_step();
	retire_t     r;
	logic [31:0] ins;
	logic [5:0]  op;
	logic [5:0]  fn;
	logic [4:0]  rs;
	logic [4:0]  rt;
	logic [4:0]  rd;
	logic [4:0]  sh;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] sext;
	logic [31:0] zext;
	logic [31:0] addr;
	logic [31:0] next_pc;
	logic        we;
	logic [4:0]  dst;
	logic [31:0] val;

	ins = m_imem[(m_pc >> 2) % IMEM_DEPTH];
	op = ins[31:26];
	fn = ins[5:0];
	rs = ins[25:21];
	rt = ins[20:16];
	rd = ins[15:11];
	sh = ins[10:6];
	a = m_regs[rs];
	b = m_regs[rt];
	sext = {{16{ins[15]}}, ins[15:0]};
	zext = {16'd0, ins[15:0]};
	addr = a + sext;
	next_pc = m_pc + 32'd4;
	we = 1'b0;
	dst = rt;
	val = 32'd0;
	r = '0;
	r.valid = 1'b1;
	r.pc = m_pc;
	r.instr = ins;

	case (op)
		OP_SPECIAL: begin
			we = 1'b1;
			dst = rd;
			case (fn)
				F_ADDU, F_ADD: val = a + b;
				F_SUBU, F_SUB: val = a - b;
				F_AND:  val = a & b;
				F_OR:   val = a | b;
				F_XOR:  val = a ^ b;
				F_NOR:  val = ~(a | b);
				F_SLT:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				F_SLTU: val = (a < b) ? 32'd1 : 32'd0;
				F_SLL:  val = b << sh;
				F_SRL:  val = b >> sh;
				F_SRA:  val = $signed(b) >>> sh;
				F_SLLV: val = b << a[4:0];
				F_SRLV: val = b >> a[4:0];
				F_SRAV: val = $signed(b) >>> a[4:0];
				F_JR: begin
					we = 1'b0;
					next_pc = a;
				end
				default: we = 1'b0;
			endcase
		end
		OP_ADDI, OP_ADDIU: begin
			we = 1'b1;
			val = a + sext;
		end
		OP_SLTI: begin
			we = 1'b1;
			val = ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0;
		end
		OP_SLTIU: begin
			we = 1'b1;
			val = (a < sext) ? 32'd1 : 32'd0;
		end
		OP_ANDI: begin
			we = 1'b1;
			val = a & zext;
		end
		OP_ORI: begin
			we = 1'b1;
			val = a | zext;
		end
		OP_XORI: begin
			we = 1'b1;
			val = a ^ zext;
		end
		OP_LUI: begin
			we = 1'b1;
			val = {ins[15:0], 16'd0};
		end
		OP_LW: begin
			we = 1'b1;
			val = m_dmem[(addr >> 2) % DMEM_DEPTH];
		end
		OP_SW: begin
			r.mem_we = 1'b1;
			r.mem_addr = addr >> 2;
			r.mem_data = b;
		end
		OP_BEQ: if (a == b) next_pc = m_pc + 32'd4 + {sext[29:0], 2'b00};
		OP_J:   next_pc = {next_pc[31:28], ins[25:0], 2'b00};
		OP_JAL: begin
			we = 1'b1;
			dst = 5'd31;
			val = m_pc + 32'd4;
			next_pc = {next_pc[31:28], ins[25:0], 2'b00};
		end
		default: ;
	endcase

	r.reg_we = we;
	r.wr_reg = dst;
	r.wr_data = val;
	if (we && dst != 5'd0)
		m_regs[dst] = val;
	if (r.mem_we)
		m_dmem[(addr >> 2) % DMEM_DEPTH] = b;
	m_pc = next_pc;
	return r;
endfunction

////////////////////////////////////////////////////////////
// Random instructions
////////////////////////////////////////////////////////////

function automatic logic [31:0] lcg_next();
	lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
	return lcg_state;
endfunction

function automatic logic [31:0] random_instr();
	logic [31:0] pick;
	logic [31:0] body;
	int          kind;

	pick = lcg_next();
	body = lcg_next();
	kind = int'(pick[31:16] % 16'd30);
	if (kind < 17)
		return {6'd0, body[25:6], R_FUNCTS[kind]};
	return {I_OPS[kind-17], body[25:0]};
endfunction

// Encoders for the directed programs
function automatic logic [31:0] r_type(logic [5:0] fn, logic [4:0] rs, logic [4:0] rt,
	logic [4:0] rd, logic [4:0] sh);
	return {6'd0, rs, rt, rd, sh, fn};
endfunction

function automatic logic [31:0] i_type(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
	logic [15:0] imm);
	return {op, rs, rt, imm};
endfunction

function automatic logic [31:0] j_type(logic [5:0] op, logic [25:0] target);
	return {op, target};
endfunction

/* tb_mips_core.sv */
`timescale 1ns/1ps

module tb_mips_core;
	import mips_pkg::*;

	localparam int IMEM_DEPTH = 256;
	localparam int DMEM_DEPTH = 64;
	localparam int RESET_CYCLES = 16;
	localparam int DIR_WORDS_MAX = 64;
	localparam int DIR_RUN_A = 20;
	localparam int GATE_IDLE = 4;
	localparam int DIR_RUN_B = 60;
	localparam int RAND_WORDS = 256;
	localparam int RAND_RUN = 600;
	// Three cycles per loaded word and some slack per task
	localparam int TOTAL_CYCLES = 2 * (RESET_CYCLES + 1) + 3 * (DIR_WORDS_MAX + RAND_WORDS) +
		DIR_RUN_A + GATE_IDLE + DIR_RUN_B + RAND_RUN + 32;
	localparam longint LIMIT_NS = 2 * TOTAL_CYCLES * 100;

	logic        clk = 1'b0;
	logic        rst_n;
	logic        run;
	logic        load_req;
	logic [31:0] load_addr;
	logic [31:0] load_data;
	logic        load_ack;
	retire_t     retire;

	logic        edge_rst_n = 1'b0;
	logic        edge_run = 1'b0;
	int          retired = 0;
	int          expected_retired = 0;
	logic [31:0] prog [$];

	`include "tb_iss.svh"

	mips_core #(.IMEM_DEPTH(IMEM_DEPTH), .DMEM_DEPTH(DMEM_DEPTH)) mips_core_i (
		.clk, .rst_n, .run, .load_req, .load_addr, .load_data, .load_ack, .retire
	);

	always #50 clk = ~clk;

	////////////////////////////////////////////////////////////
	// Checking
	////////////////////////////////////////////////////////////

	task automatic report_failure(string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
		assert (got == exp) else begin
			$display("FAILED %s: got %h expected %h", name, got, exp);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	// What the DUT saw at the last rising edge
	always @(posedge clk) begin
		edge_rst_n <= rst_n;
		edge_run <= run;
	end

	always @(negedge clk) begin
		retire_t exp;
		if (edge_rst_n) begin
			check_value("retire.valid", 32'(retire.valid), 32'(edge_run));
			if (retire.valid) begin
				exp = iss_step();
				check_value("retire.pc", retire.pc, exp.pc);
				check_value("retire.instr", retire.instr, exp.instr);
				check_value("retire.reg_we", 32'(retire.reg_we), 32'(exp.reg_we));
				if (exp.reg_we) begin
					check_value("retire.wr_reg", 32'(retire.wr_reg), 32'(exp.wr_reg));
					check_value("retire.wr_data", retire.wr_data, exp.wr_data);
				end
				check_value("retire.mem_we", 32'(retire.mem_we), 32'(exp.mem_we));
				if (exp.mem_we) begin
					check_value("retire.mem_addr", retire.mem_addr, exp.mem_addr);
					check_value("retire.mem_data", retire.mem_data, exp.mem_data);
				end
				retired++;
			end
		end
	end

	initial begin
		#(LIMIT_NS);
		$display("Timeout: the run went past its cycle limit");
		$display("TEST FAILED");
		$fatal(1);
	end

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	task automatic apply_reset();
		@(negedge clk);
		rst_n = 1'b0;
		// Reset must win over run
		run = 1'b1;
		repeat (RESET_CYCLES) @(negedge clk);
		assert (!retire.valid && !load_ack) else
			report_failure("retire.valid or load_ack is high at the end of reset");
		rst_n = 1'b1;
		run = 1'b0;
		model_reset();
	endtask

	task automatic load_word(logic [31:0] addr, logic [31:0] data);
		int waited;
		waited = 0;
		@(negedge clk);
		assert (!load_ack) else report_failure("load_ack high before the request");
		load_addr = addr;
		load_data = data;
		load_req = 1'b1;
		@(negedge clk);
		while (!load_ack && waited < 8) begin
			@(negedge clk);
			waited++;
		end
		assert (load_ack) else report_failure("load_ack never rose for a load request");
		load_req = 1'b0;
		@(negedge clk);
		assert (!load_ack) else report_failure("load_ack did not fall after load_req fell");
		m_imem[addr % IMEM_DEPTH] = data;
	endtask

	task automatic run_cycles(int n);
		@(negedge clk);
		run = 1'b1;
		repeat (n) @(negedge clk);
		run = 1'b0;
		expected_retired += n;
	endtask

	task automatic build_directed();
		prog.delete();
		// ALU
		prog.push_back(i_type(OP_LUI, 0, 1, 16'h8765));
		prog.push_back(i_type(OP_ORI, 1, 1, 16'h4321));
		prog.push_back(i_type(OP_ADDIU, 0, 2, 16'hfffb));
		prog.push_back(i_type(OP_ADDI, 0, 3, 16'd7));
		prog.push_back(r_type(F_ADDU, 1, 2, 4, 0));
		prog.push_back(r_type(F_SUBU, 3, 2, 5, 0));
		prog.push_back(r_type(F_ADD, 2, 3, 6, 0));
		prog.push_back(r_type(F_SUB, 2, 3, 7, 0));
		prog.push_back(r_type(F_AND, 1, 2, 8, 0));
		prog.push_back(r_type(F_OR, 1, 3, 9, 0));
		prog.push_back(r_type(F_XOR, 1, 2, 10, 0));
		prog.push_back(r_type(F_NOR, 1, 3, 11, 0));
		prog.push_back(r_type(F_SLT, 2, 3, 12, 0));
		prog.push_back(r_type(F_SLTU, 2, 3, 13, 0));
		prog.push_back(i_type(OP_SLTI, 2, 14, 16'hffff));
		prog.push_back(i_type(OP_SLTIU, 3, 15, 16'hfff0));
		prog.push_back(i_type(OP_ANDI, 1, 16, 16'hf0f0));
		prog.push_back(i_type(OP_XORI, 2, 17, 16'h1234));
		prog.push_back(r_type(F_SLL, 0, 1, 18, 4));
		prog.push_back(r_type(F_SRL, 0, 1, 19, 8));
		prog.push_back(r_type(F_SRA, 0, 1, 20, 8));
		prog.push_back(r_type(F_SLLV, 3, 1, 21, 0));
		prog.push_back(r_type(F_SRLV, 3, 1, 22, 0));
		prog.push_back(r_type(F_SRAV, 3, 1, 23, 0));
		prog.push_back(r_type(F_ADDU, 1, 1, 0, 0));
		// Two undefined words
		prog.push_back(32'hfc000000);
		prog.push_back(r_type(6'h01, 1, 2, 3, 0));
		// The second memory base wraps onto the first
		prog.push_back(i_type(OP_ADDIU, 0, 24, 16'h0100));
		prog.push_back(i_type(OP_SW, 24, 4, 16'h0000));
		prog.push_back(i_type(OP_SW, 24, 1, 16'h0004));
		prog.push_back(i_type(OP_SW, 24, 2, 16'hfffc));
		prog.push_back(i_type(OP_ADDIU, 24, 25, 16'(DMEM_DEPTH * 4)));
		prog.push_back(i_type(OP_LW, 25, 26, 16'h0000));
		prog.push_back(i_type(OP_LW, 24, 27, 16'h0004));
		prog.push_back(i_type(OP_LW, 25, 28, 16'hfffc));
		// Control flow
		prog.push_back(i_type(OP_BEQ, 0, 0, 16'd1));
		prog.push_back(i_type(OP_ADDIU, 0, 5, 16'hdead));
		prog.push_back(i_type(OP_BEQ, 1, 2, 16'd1));
		prog.push_back(i_type(OP_ADDIU, 0, 5, 16'd1));
		prog.push_back(j_type(OP_JAL, 26'd41));
		prog.push_back(j_type(OP_J, 26'd43));
		prog.push_back(i_type(OP_ADDIU, 0, 6, 16'd3));
		prog.push_back(r_type(F_JR, 31, 0, 0, 0));
		prog.push_back(r_type(F_ADDU, 31, 6, 29, 0));
		// Park on a self jump
		prog.push_back(j_type(OP_J, 26'd44));
	endtask

	initial begin
		rst_n = 1'b0;
		run = 1'b0;
		load_req = 1'b0;
		load_addr = 32'd0;
		load_data = 32'd0;
		for (int i = 0; i < IMEM_DEPTH; i++)
			m_imem[i] = 32'd0;
		model_reset();

		apply_reset();
		build_directed();
		foreach (prog[i])
			load_word(32'(i), prog[i]);
		run_cycles(DIR_RUN_A);
		// Paused core must not retire
		repeat (GATE_IDLE) @(negedge clk);
		run_cycles(DIR_RUN_B);

		apply_reset();
		for (int i = 0; i < RAND_WORDS; i++)
			load_word(32'(i), random_instr());
		run_cycles(RAND_RUN);
		repeat (2) @(negedge clk);

		if (retired == expected_retired) begin
			$display("TEST OK");
			$finish;
		end else begin
			$display("Retired %0d instructions, expected %0d", retired, expected_retired);
			$display("TEST FAILED");
			$fatal(1);
		end
	end

endmodule

/* src.f */
+incdir+.
mips_pkg.sv
mips_controller.sv
mips_fetch.sv
mips_regfile.sv
mips_execute.sv
mips_data_mem.sv
mips_core.sv
tb_mips_core.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary -f src.f --top-module tb_mips_core -o Vtb_mips_core
output=$(./obj_dir/Vtb_mips_core || true)
echo "$output"
if echo "$output" | grep -qx "TEST OK"; then
	exit 0
else
	exit 1
fi
